// File: project.f
verilog/dii_pkg.sv
verilog/event_packetizer.sv
verilog/event_packetizer_fixedwidth.sv
verilog/flit_arbiter.sv
verilog/event_trace_top.sv
tb/event_trace_chk.sv
tb/event_trace_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator; exit status is nonzero unless the testbench passes
verilator --binary --assert -Wno-fatal --top-module event_trace_tb -f project.f \
   && ./obj_dir/Vevent_trace_tb | tee /dev/stderr | grep -q "Everything OK" \
   || { echo "Simulation did not pass"; exit 1; }

// File: tb/event_trace_tb.sv
// Self-checking testbench for the trace top; source ids must differ, random stimulus has a fixed seed
`default_nettype none

module event_trace_tb;
   import dii_pkg::*;

   localparam int CLK_PERIOD = 8;
   localparam int RAND_RECORDS = 20;
   // Cycles a source waits for consumed before giving up
   localparam int RECORD_TIMEOUT = 200;
   localparam int CW = FLIT_WIDTH + 1;
   localparam logic [FLIT_WIDTH-1:0] DEST_ADDR = 16'h0d0e;
   localparam logic [FLIT_WIDTH-1:0] SRC0_ID = 16'h00a0;
   localparam logic [FLIT_WIDTH-1:0] SRC1_ID = 16'h00b1;
   // Worst-case flits of one record, headers included
   localparam int REC0_FLITS = 6;
   localparam int REC1_FLITS = 11;
   localparam int OVF_FLITS = HDR_FLITS + 1;
   // Tests 1 to 3, then three records per source in test 4, then the random test
   localparam int TOTAL_FLITS = REC0_FLITS + REC1_FLITS + 2 * OVF_FLITS +
                                (3 + RAND_RECORDS) * (REC0_FLITS + REC1_FLITS);
   localparam int WATCHDOG_TIME = (TOTAL_FLITS * 4 + 5) * CLK_PERIOD;

   logic                       clk;
   logic                       arst_n;
   logic [FLIT_WIDTH-1:0]      src0_id;
   logic [FLIT_WIDTH-1:0]      src1_id;
   logic [FLIT_WIDTH-1:0]      dest;
   logic                       ev0_available;
   logic                       ev0_overflow;
   logic [SRC0_DATA_WIDTH-1:0] ev0_data;
   logic                       ev0_consumed;
   logic                       ev1_available;
   logic                       ev1_overflow;
   logic [SRC1_DATA_WIDTH-1:0] ev1_data;
   logic                       ev1_consumed;
   logic                       dbg_valid;
   logic                       dbg_last;
   logic [FLIT_WIDTH-1:0]      dbg_data;
   logic                       dbg_ready;

   // Expected {last, data} flits per source, in order
   logic [FLIT_WIDTH:0] exp0_q[$];
   logic [FLIT_WIDTH:0] exp1_q[$];
   // Flits of the packet now on the output
   logic [FLIT_WIDTH:0] pkt_q[$];
   integer              seed = 32'h4076_1bcf;
   logic [31:0]         rnd;
   int                  n_checks;
   int                  n_errors;
   // Source of the previous packet, -1 before the first one
   int                  prev_src;
   bit                  rr_check;
   bit                  rand_ready;

   event_trace_top i_event_trace_top (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_value(input logic [CW-1:0] got, input logic [CW-1:0] exp_val,
                              input string what);
      n_checks++;
      if (got !== exp_val) begin
         n_errors++;
         $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp_val);
      end
   endtask

   // Expected flits of one record: headers, FIRST then CONT, or a single OVERFLOW packet
   function automatic void build_ref(input int src, input logic [SRC1_DATA_WIDTH-1:0] rec,
                                     input bit ovf, input int width);
      int                    n_words;
      int                    w;
      int                    pay;
      int                    b;
      logic [FLIT_WIDTH-1:0] word;
      logic [FLIT_WIDTH:0]   flits[$];
      pkt_sub_e              sub;
      n_words = ovf ? 1 : (width + FLIT_WIDTH - 1) / FLIT_WIDTH;
      w = 0;
      while (w < n_words) begin
         sub = ovf ? SUB_OVERFLOW : ((w == 0) ? SUB_FIRST : SUB_CONT);
         flits.push_back({1'b0, DEST_ADDR});
         flits.push_back({1'b0, (src == 0) ? SRC0_ID : SRC1_ID});
         flits.push_back({1'b0, EVENT, sub, 10'd0});
         for (pay = 0; pay < MAX_PKT_LEN - HDR_FLITS && w < n_words; pay++) begin
            // Word w is record bits 16w+15..16w, zero above the record width
            for (b = 0; b < FLIT_WIDTH; b++) begin
               word[b] = (w * FLIT_WIDTH + b < width) ? rec[w * FLIT_WIDTH + b] : 1'b0;
            end
            flits.push_back({(pay == MAX_PKT_LEN - HDR_FLITS - 1) || (w == n_words - 1), word});
            w++;
         end
      end
      foreach (flits[i]) begin
         if (src == 0) begin
            exp0_q.push_back(flits[i]);
         end else begin
            exp1_q.push_back(flits[i]);
         end
      end
   endfunction

   function automatic logic [SRC1_DATA_WIDTH-1:0] rand_rec();
      return SRC1_DATA_WIDTH'({$random(seed), $random(seed), $random(seed)});
   endfunction

   // Offer one record and hold it until consumed
   task automatic send_record(input int src, input logic [SRC1_DATA_WIDTH-1:0] rec, input bit ovf);
      int cycles;
      bit done;
      build_ref(src, rec, ovf, (src == 0) ? SRC0_DATA_WIDTH : SRC1_DATA_WIDTH);
      @(posedge clk);
      if (src == 0) begin
         ev0_available <= 1'b1;
         ev0_overflow <= ovf;
         ev0_data <= rec[SRC0_DATA_WIDTH-1:0];
      end else begin
         ev1_available <= 1'b1;
         ev1_overflow <= ovf;
         ev1_data <= rec;
      end
      cycles = 0;
      done = 1'b0;
      while (!done && cycles < RECORD_TIMEOUT) begin
         @(posedge clk);
         cycles++;
         done = (src == 0) ? ev0_consumed : ev1_consumed;
      end
      if (done) begin
         // Consumed must coincide with the last flit of this source being accepted
         check_value(CW'({dbg_valid, dbg_ready, dbg_last, (src == 0) ?
                          i_event_trace_top.p0_ready : i_event_trace_top.p1_ready}),
                     CW'(4'hf), "consumed away from the final flit");
      end else begin
         n_errors++;
         $display("Source %0d: consumed never came within %0d cycles", src, RECORD_TIMEOUT);
      end
      if (src == 0) begin
         ev0_available <= 1'b0;
      end else begin
         ev1_available <= 1'b0;
      end
   endtask

   // Sort a finished packet by its source-id flit and compare it flit by flit
   task automatic compare_packet();
      logic [FLIT_WIDTH:0] exp_flit;
      bit                  is_src1;
      int                  i;
      if (pkt_q.size() < HDR_FLITS || (pkt_q[1][FLIT_WIDTH-1:0] != SRC0_ID &&
                                       pkt_q[1][FLIT_WIDTH-1:0] != SRC1_ID)) begin
         n_errors++;
         $display("Packet of %0d flits with an unknown source id at %0t", pkt_q.size(), $time);
      end else begin
         is_src1 = (pkt_q[1][FLIT_WIDTH-1:0] == SRC1_ID);
         for (i = 0; i < pkt_q.size(); i++) begin
            if ((is_src1 ? exp1_q.size() : exp0_q.size()) == 0) begin
               n_errors++;
               $display("Unexpected flit from source %0d at %0t", is_src1, $time);
               i = pkt_q.size();
            end else begin
               exp_flit = is_src1 ? exp1_q.pop_front() : exp0_q.pop_front();
               check_value(pkt_q[i], exp_flit, "packet flit {last, data}");
            end
         end
      end
      pkt_q.delete();
   endtask

   // Output monitor
   always @(posedge clk) begin
      if (arst_n && dbg_valid && dbg_ready) begin
         if (pkt_q.size() == 0) begin
            // Both requesting at a boundary, so the grant must switch source
            if (rr_check && prev_src >= 0 && i_event_trace_top.p0_valid &&
                i_event_trace_top.p1_valid) begin
               check_value(CW'(i_event_trace_top.p1_ready), CW'(prev_src == 0),
                           "round robin at packet boundary");
            end
            prev_src = i_event_trace_top.p1_ready ? 1 : 0;
         end
         pkt_q.push_back({dbg_last, dbg_data});
         if (dbg_last) begin
            compare_packet();
         end
      end
   end

   // About one cycle in four stalled
   always @(posedge clk) begin
      if (rand_ready) begin
         rnd = $random(seed);
         dbg_ready <= (rnd[1:0] != 2'b00);
      end
   end

   task automatic finish_test(input int num, input string name);
      repeat (3) @(posedge clk);
      if (exp0_q.size() != 0 || exp1_q.size() != 0 || pkt_q.size() != 0) begin
         n_errors++;
         $display("Test %0d: %0d source 0 and %0d source 1 flits missing, %0d in an open packet",
                  num, exp0_q.size(), exp1_q.size(), pkt_q.size());
         exp0_q.delete();
         exp1_q.delete();
         pkt_q.delete();
      end
      $display("Test %0d %s finished, %0d errors so far", num, name, n_errors);
   endtask

   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired, the tests did not finish in time");
      $display("Something failed");
      $finish;
   end

   initial begin
      arst_n = 1'b0;
      src0_id = SRC0_ID;
      src1_id = SRC1_ID;
      dest = DEST_ADDR;
      ev0_available = 1'b0;
      ev0_overflow = 1'b0;
      ev0_data = '0;
      ev1_available = 1'b0;
      ev1_overflow = 1'b0;
      ev1_data = '0;
      dbg_ready = 1'b1;
      n_checks = 0;
      n_errors = 0;
      prev_src = -1;
      rr_check = 1'b0;
      rand_ready = 1'b0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      send_record(0, rand_rec(), 1'b0);
      finish_test(1, "single source 0 record");
      send_record(1, rand_rec(), 1'b0);
      finish_test(2, "split source 1 record");
      send_record(0, rand_rec(), 1'b1);
      send_record(1, rand_rec(), 1'b1);
      finish_test(3, "overflow on both sources");
      rr_check = 1'b1;
      fork
         repeat (3) send_record(0, rand_rec(), 1'b0);
         repeat (3) send_record(1, rand_rec(), 1'b0);
      join
      rr_check = 1'b0;
      finish_test(4, "both sources together");
      rand_ready = 1'b1;
      fork
         repeat (RAND_RECORDS) send_record(0, rand_rec(), ($random(seed) % 8) == 0);
         repeat (RAND_RECORDS) send_record(1, rand_rec(), ($random(seed) % 8) == 0);
      join
      rand_ready = 1'b0;
      @(posedge clk);
      dbg_ready <= 1'b1;
      finish_test(5, "random records under back-pressure");
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/event_trace_chk.sv
// Output link checker bound into the trace top; single clock, active-low async reset assumed
`default_nettype none

module event_trace_chk (
   input wire logic                           clk,
   input wire logic                           arst_n,
   input wire logic                           dbg_valid,
   input wire logic                           dbg_last,
   input wire logic [dii_pkg::FLIT_WIDTH-1:0] dbg_data,
   input wire logic                           dbg_ready,
   input wire logic                           ev0_consumed,
   input wire logic                           ev1_consumed
);
   // Nothing leaves the link while reset is held
   a_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !dbg_valid)
      else $error("dbg_valid high during reset");

   // Stalled flit stays put until it is taken
   a_hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
      dbg_valid && !dbg_ready |=> dbg_valid && $stable(dbg_last) && $stable(dbg_data))
      else $error("output flit changed while stalled");

   // Consumed is a single-cycle pulse
   a_consumed0_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      ev0_consumed |=> !ev0_consumed)
      else $error("ev0_consumed longer than one cycle");
   a_consumed1_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      ev1_consumed |=> !ev1_consumed)
      else $error("ev1_consumed longer than one cycle");

   a_last_with_valid: assert property (@(posedge clk) disable iff (!arst_n)
      dbg_last |-> dbg_valid)
      else $error("dbg_last without dbg_valid");

endmodule

bind event_trace_top event_trace_chk i_chk (
   .clk(clk),
   .arst_n(arst_n),
   .dbg_valid(dbg_valid),
   .dbg_last(dbg_last),
   .dbg_data(dbg_data),
   .dbg_ready(dbg_ready),
   .ev0_consumed(ev0_consumed),
   .ev1_consumed(ev1_consumed)
);

`default_nettype wire

// File: verilog/event_trace_top.sv
// Debug trace top with two fixed-width sources sharing one output; no link flow control beyond ready
`default_nettype none

module event_trace_top (
   input  wire logic                                 clk,
   input  wire logic                                 arst_n,

   // Addresses
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0]       src0_id,
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0]       src1_id,
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0]       dest,

   // Event source 0
   input  wire logic                                 ev0_available,
   input  wire logic                                 ev0_overflow,
   input  wire logic [dii_pkg::SRC0_DATA_WIDTH-1:0]  ev0_data,
   output logic                                      ev0_consumed,

   // Event source 1
   input  wire logic                                 ev1_available,
   input  wire logic                                 ev1_overflow,
   input  wire logic [dii_pkg::SRC1_DATA_WIDTH-1:0]  ev1_data,
   output logic                                      ev1_consumed,

   // Debug output link
   output logic                                      dbg_valid,
   output logic                                      dbg_last,
   output logic [dii_pkg::FLIT_WIDTH-1:0]            dbg_data,
   input  wire logic                                 dbg_ready
);
   import dii_pkg::*;

   // Packetizer to arbiter links
   logic                  p0_valid;
   logic                  p0_last;
   logic [FLIT_WIDTH-1:0] p0_data;
   logic                  p0_ready;
   logic                  p1_valid;
   logic                  p1_last;
   logic [FLIT_WIDTH-1:0] p1_data;
   logic                  p1_ready;

   event_packetizer_fixedwidth #(
      .DATA_WIDTH(SRC0_DATA_WIDTH)
   ) u_src0 (
      .clk(clk),
      .arst_n(arst_n),
      .id(src0_id),
      .dest(dest),
      .overflow(ev0_overflow),
      .event_available(ev0_available),
      .event_consumed(ev0_consumed),
      .data(ev0_data),
      .flit_valid(p0_valid),
      .flit_last(p0_last),
      .flit_data(p0_data),
      .flit_ready(p0_ready)
   );

   event_packetizer_fixedwidth #(
      .DATA_WIDTH(SRC1_DATA_WIDTH)
   ) u_src1 (
      .clk(clk),
      .arst_n(arst_n),
      .id(src1_id),
      .dest(dest),
      .overflow(ev1_overflow),
      .event_available(ev1_available),
      .event_consumed(ev1_consumed),
      .data(ev1_data),
      .flit_valid(p1_valid),
      .flit_last(p1_last),
      .flit_data(p1_data),
      .flit_ready(p1_ready)
   );

   // Source 0 preferred out of reset
   flit_arbiter u_arb (
      .clk(clk),
      .arst_n(arst_n),
      .p0_valid(p0_valid),
      .p0_last(p0_last),
      .p0_data(p0_data),
      .p0_ready(p0_ready),
      .p1_valid(p1_valid),
      .p1_last(p1_last),
      .p1_data(p1_data),
      .p1_ready(p1_ready),
      .dbg_valid(dbg_valid),
      .dbg_last(dbg_last),
      .dbg_data(dbg_data),
      .dbg_ready(dbg_ready)
   );

endmodule

`default_nettype wire

// File: verilog/flit_arbiter.sv
// Two-input packet arbiter; senders must hold valid until transfer, grant locks per packet
`default_nettype none

module flit_arbiter (
   input  wire logic                           clk,
   input  wire logic                           arst_n,

   // Packetizer 0 link
   input  wire logic                           p0_valid,
   input  wire logic                           p0_last,
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0] p0_data,
   output logic                                p0_ready,

   // Packetizer 1 link
   input  wire logic                           p1_valid,
   input  wire logic                           p1_last,
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0] p1_data,
   output logic                                p1_ready,

   // Shared debug output
   output logic                                dbg_valid,
   output logic                                dbg_last,
   output logic [dii_pkg::FLIT_WIDTH-1:0]      dbg_data,
   input  wire logic                           dbg_ready
);
   // Held while a packet is in flight or stalled
   logic locked_q;
   logic grant_q;
   // Preferred source when both request at a boundary
   logic pref_q;
   logic pick;
   logic sel;

   // Round robin at a packet boundary
   assign pick = (p0_valid && p1_valid) ? pref_q : p1_valid && !p0_valid;
   assign sel = locked_q ? grant_q : pick;

   // Zero-latency pass-through of the granted source
   assign dbg_valid = sel ? p1_valid : p0_valid;
   assign dbg_last = sel ? p1_last : p0_last;
   assign dbg_data = sel ? p1_data : p0_data;

   assign p0_ready = dbg_ready && !sel;
   assign p1_ready = dbg_ready && sel;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         locked_q <= 1'b0;
         grant_q  <= 1'b0;
         pref_q   <= 1'b0;
      end else if (dbg_valid) begin
         if (dbg_ready && dbg_last) begin
            // End of packet, other source goes first next time
            locked_q <= 1'b0;
            pref_q   <= !sel;
         end else begin
            locked_q <= 1'b1;
            grant_q  <= sel;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/event_packetizer_fixedwidth.sv
// Fixed-width record front end; record must stay stable until consumed, word 0 is bits 15..0
`default_nettype none

module event_packetizer_fixedwidth #(
   parameter int DATA_WIDTH = 40
) (
   input  wire logic                           clk,
   input  wire logic                           arst_n,
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0] id,
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0] dest,
   input  wire logic                           overflow,
   input  wire logic                           event_available,
   output logic                                event_consumed,
   input  wire logic [DATA_WIDTH-1:0]          data,
   output logic                                flit_valid,
   output logic                                flit_last,
   output logic [dii_pkg::FLIT_WIDTH-1:0]      flit_data,
   input  wire logic                           flit_ready
);
   import dii_pkg::*;

   // Record length in whole flit words
   localparam int NUM_WORDS = (DATA_WIDTH + FLIT_WIDTH - 1) / FLIT_WIDTH;
   localparam int IDX_W = $clog2(NUM_WORDS > 1 ? NUM_WORDS : 2);
   localparam int PAD_WIDTH = NUM_WORDS * FLIT_WIDTH;

   logic [IDX_W-1:0]      word_idx;
   logic [FLIT_WIDTH-1:0] word;
   // Zero-extended record, upper bits of the last word are zero
   logic [PAD_WIDTH-1:0]  data_pad;

   assign data_pad = PAD_WIDTH'(data);

   always_comb begin
      if (32'(word_idx) < NUM_WORDS) begin
         word = data_pad[word_idx*FLIT_WIDTH +: FLIT_WIDTH];
      end else begin
         word = '0;
      end
   end

   event_packetizer #(
      .MAX_DATA_NUM_WORDS(NUM_WORDS)
   ) u_packetizer (
      .clk(clk),
      .arst_n(arst_n),
      .id(id),
      .dest(dest),
      .overflow(overflow),
      .event_available(event_available),
      .event_consumed(event_consumed),
      .word_idx(word_idx),
      .word(word),
      .flit_valid(flit_valid),
      .flit_last(flit_last),
      .flit_data(flit_data),
      .flit_ready(flit_ready)
   );

endmodule

`default_nettype wire

// File: verilog/event_packetizer.sv
// Event packetizer; source must hold overflow and the requested word stable until consumed
`default_nettype none

module event_packetizer #(
   parameter int MAX_DATA_NUM_WORDS = 2
) (
   input  wire logic                                   clk,
   input  wire logic                                   arst_n,

   // Own address and event destination
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0]         id,
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0]         dest,

   // Event handshake
   input  wire logic                                   overflow,
   input  wire logic                                   event_available,
   output logic                                        event_consumed,

   // Payload word request, answered combinationally
   output logic [$clog2(MAX_DATA_NUM_WORDS > 1 ? MAX_DATA_NUM_WORDS : 2)-1:0] word_idx,
   input  wire logic [dii_pkg::FLIT_WIDTH-1:0]         word,

   // Outgoing flit link
   output logic                                        flit_valid,
   output logic                                        flit_last,
   output logic [dii_pkg::FLIT_WIDTH-1:0]              flit_data,
   input  wire logic                                   flit_ready
);
   import dii_pkg::*;

   // Payload flits per packet
   localparam int PAYLOAD_FLITS = MAX_PKT_LEN - HDR_FLITS;
   localparam int CNT_W = $clog2(PAYLOAD_FLITS + 1);
   localparam int IDX_W = $bits(word_idx);
   // Zero bits below the sub type in the type word
   localparam int TYPE_PAD = FLIT_WIDTH - $bits(pkt_type_e) - $bits(pkt_sub_e);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_DEST,
      ST_SRC,
      ST_TYPE,
      ST_PAYLOAD,
      ST_DONE
   } state_e;

   state_e           state;
   logic [CNT_W-1:0] pay_cnt;
   // Set while the current packet is the first of its record
   logic             first_q;
   // Overflow request latched when the record is taken
   logic             ovf_q;
   logic             rec_done;
   logic             pkt_full;
   logic             xfer;
   pkt_sub_e         sub;

   // Last word of the record; an overflow packet carries word 0 only
   assign rec_done = ovf_q || (word_idx == IDX_W'(MAX_DATA_NUM_WORDS - 1));
   assign pkt_full = (pay_cnt == CNT_W'(PAYLOAD_FLITS - 1));
   assign xfer = flit_valid && flit_ready;

   assign sub = ovf_q ? SUB_OVERFLOW : (first_q ? SUB_FIRST : SUB_CONT);

   assign flit_valid = (state == ST_DEST) || (state == ST_SRC) ||
                       (state == ST_TYPE) || (state == ST_PAYLOAD);
   assign flit_last = (state == ST_PAYLOAD) && (rec_done || pkt_full);

   // Record finished with the final accepted flit
   assign event_consumed = xfer && flit_last && rec_done;

   always_comb begin
      case (state)
         ST_DEST: flit_data = dest;
         ST_SRC:  flit_data = id;
         ST_TYPE: flit_data = {EVENT, sub, {TYPE_PAD{1'b0}}};
         ST_PAYLOAD: flit_data = word;
         default: flit_data = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= ST_IDLE;
         pay_cnt  <= '0;
         word_idx <= '0;
         first_q  <= 1'b0;
         ovf_q    <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               // Take a new record, first header flit valid next cycle
               if (event_available) begin
                  state    <= ST_DEST;
                  pay_cnt  <= '0;
                  word_idx <= '0;
                  first_q  <= 1'b1;
                  ovf_q    <= overflow;
               end
            end
            ST_DEST: begin
               if (flit_ready) begin
                  state <= ST_SRC;
               end
            end
            ST_SRC: begin
               if (flit_ready) begin
                  state <= ST_TYPE;
               end
            end
            ST_TYPE: begin
               if (flit_ready) begin
                  state   <= ST_PAYLOAD;
                  pay_cnt <= '0;
               end
            end
            ST_PAYLOAD: begin
               if (flit_ready) begin
                  if (!rec_done) begin
                     word_idx <= word_idx + 1'b1;
                  end
                  if (flit_last && rec_done) begin
                     state <= ST_DONE;
                  end else if (flit_last) begin
                     // Packet full, reopen as a continuation
                     state   <= ST_DEST;
                     first_q <= 1'b0;
                     pay_cnt <= '0;
                  end else begin
                     pay_cnt <= pay_cnt + 1'b1;
                  end
               end
            end
            // One idle cycle so the source can drop available
            ST_DONE: state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/dii_pkg.sv
// Debug trace constants and encodings; 16-bit flits with a fixed three-flit header only
`default_nettype none

package dii_pkg;

   // One flit on every debug link
   localparam int FLIT_WIDTH = 16;

   // Destination, source id and type word
   localparam int HDR_FLITS = 3;

   // Whole packet including the header flits
   localparam int MAX_PKT_LEN = 6;

   // Record widths of the two event sources
   // 3 words, top byte of word 2 padded
   localparam int SRC0_DATA_WIDTH = 40;
   // 5 words, splits into two packets
   localparam int SRC1_DATA_WIDTH = 72;

   // Packet type field, bits 15..14 of the type word
   typedef enum logic [1:0] {
      EVENT = 2'd2
   } pkt_type_e;

   // Sub type field, bits 13..10 of the type word
   typedef enum logic [3:0] {
      // First or only packet of a record
      SUB_FIRST    = 4'd0,
      // Follow-on packet of a split record
      SUB_CONT     = 4'd1,
      // Lost events, count in the single payload flit
      SUB_OVERFLOW = 4'd5
   } pkt_sub_e;

endpackage

`default_nettype wire
